/* ahbl_xbar.f */
common/ahbl_pkg.sv
common/xbar_cfg_pkg.sv
hw/ahbl_crossbar/ahbl_splitter.sv
hw/ahbl_crossbar/ahbl_arbiter.sv
hw/ahbl_crossbar/ahbl_crossbar.sv
hw/ahbl_sram.sv
hw/ahbl_xbar_sys.sv
verif/tb_ahbl_xbar_sys.sv

/* common/ahbl_pkg.sv */
// AHB-Lite bus widths and the transfer type, size and response encodings
package ahbl_pkg;

	// ========================================================================
	// Bus widths
	// ========================================================================

	localparam int W_ADDR = 32;
	localparam int W_DATA = 32;
	localparam int BYTE_LANES = W_DATA / 8;

	// ========================================================================
	// Encodings
	// ========================================================================

	// HTRANS
	typedef enum logic [1:0] {
		HTRANS_IDLE   = 2'b00,
		HTRANS_BUSY   = 2'b01,
		HTRANS_NONSEQ = 2'b10,
		HTRANS_SEQ    = 2'b11
	} ahbl_trans_t;

	// Byte, halfword and word transfers
	typedef enum logic [2:0] {
		HSIZE_BYTE = 3'b000,
		HSIZE_HALF = 3'b001,
		HSIZE_WORD = 3'b010
	} ahbl_size_t;

	// HRESP
	typedef enum logic {
		HRESP_OKAY  = 1'b0,
		HRESP_ERROR = 1'b1
	} ahbl_resp_t;

endpackage

/* common/xbar_cfg_pkg.sv */
// Crossbar port counts, slave address map and SRAM depth
package xbar_cfg_pkg;

	// ========================================================================
	// Port counts
	// ========================================================================

	localparam int N_MASTERS = 2;
	localparam int N_SLAVES = 2;

	// ========================================================================
	// Address map
	// ========================================================================

	// Slave j is selected when (haddr & SLAVE_MASK[j]) == SLAVE_BASE[j]
	localparam logic [N_SLAVES-1:0][ahbl_pkg::W_ADDR-1:0] SLAVE_BASE = {
		32'h1000_0000,
		32'h0000_0000
	};

	localparam logic [N_SLAVES-1:0][ahbl_pkg::W_ADDR-1:0] SLAVE_MASK = {
		32'hf000_0000,
		32'hf000_0000
	};

	// SRAM geometry
	localparam int SRAM_WORDS = 256;
	localparam int SRAM_IDX_W = $clog2(SRAM_WORDS);

endpackage

/* hw/ahbl_crossbar/ahbl_arbiter.sv */
// Per-slave fixed-priority AHB-Lite arbiter with per-master address hold registers
`timescale 1ns/10ps

module ahbl_arbiter #(
	parameter int N_PORTS = xbar_cfg_pkg::N_MASTERS
) (
	input  logic                                         clk,
	input  logic                                         rst,

	// Source side, one port per master
	input  logic [N_PORTS-1:0]                           src_hready,
	input  logic [N_PORTS-1:0][ahbl_pkg::W_ADDR-1:0]     src_haddr,
	input  logic [N_PORTS-1:0]                           src_hwrite,
	input  ahbl_pkg::ahbl_trans_t [N_PORTS-1:0]          src_htrans,
	input  ahbl_pkg::ahbl_size_t [N_PORTS-1:0]           src_hsize,
	input  logic [N_PORTS-1:0][ahbl_pkg::W_DATA-1:0]     src_hwdata,
	output logic [N_PORTS-1:0][ahbl_pkg::W_DATA-1:0]     src_hrdata,
	output logic [N_PORTS-1:0]                           src_hready_resp,
	output ahbl_pkg::ahbl_resp_t [N_PORTS-1:0]           src_hresp,

	// Destination side, facing one slave
	output logic                                         dst_hready,
	output logic [ahbl_pkg::W_ADDR-1:0]                  dst_haddr,
	output logic                                         dst_hwrite,
	output ahbl_pkg::ahbl_trans_t                        dst_htrans,
	output ahbl_pkg::ahbl_size_t                         dst_hsize,
	output logic [ahbl_pkg::W_DATA-1:0]                  dst_hwdata,
	input  logic [ahbl_pkg::W_DATA-1:0]                  dst_hrdata,
	input  logic                                         dst_hready_resp,
	input  ahbl_pkg::ahbl_resp_t                         dst_hresp
);

	import ahbl_pkg::*;

	logic [N_PORTS-1:0]             req;
	logic [N_PORTS-1:0]             grant;
	logic                           grant_hold;
	logic [N_PORTS-1:0]             dp_owner;
	logic [N_PORTS-1:0]             hold_valid;
	logic [N_PORTS-1:0][W_ADDR-1:0] hold_addr;
	logic [N_PORTS-1:0]             hold_write;
	ahbl_size_t [N_PORTS-1:0]       hold_size;

	// A request is a NONSEQ that the master sees accepted this cycle
	always_comb begin
		for (int i = 0; i < N_PORTS; i++) begin
			req[i] = src_hready[i] && (src_htrans[i] == HTRANS_NONSEQ);
		end
	end

	// ========================================================================
	// Grant selection
	// ========================================================================

	// Buffered requests go first, then the lowest-numbered live one
	always_comb begin
		grant      = '0;
		grant_hold = |hold_valid;
		for (int i = N_PORTS - 1; i >= 0; i--) begin
			if (grant_hold ? hold_valid[i] : req[i]) begin
				grant    = '0;
				grant[i] = 1'b1;
			end
		end
		// Nothing issues while the slave stretches a data phase
		if (!dst_hready_resp) begin
			grant = '0;
		end
	end

	// Address phase to the slave
	always_comb begin
		dst_htrans = HTRANS_IDLE;
		dst_haddr  = '0;
		dst_hwrite = 1'b0;
		dst_hsize  = HSIZE_WORD;
		for (int i = 0; i < N_PORTS; i++) begin
			if (grant[i]) begin
				dst_htrans = HTRANS_NONSEQ;
				dst_haddr  = grant_hold ? hold_addr[i] : src_haddr[i];
				dst_hwrite = grant_hold ? hold_write[i] : src_hwrite[i];
				dst_hsize  = grant_hold ? hold_size[i] : src_hsize[i];
			end
		end
	end

	assign dst_hready = dst_hready_resp;

	// ========================================================================
	// Hold registers and data phase owner
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			hold_valid <= '0;
			dp_owner   <= '0;
		end else begin
			if (dst_hready_resp) begin
				dp_owner <= grant;
			end
			for (int i = 0; i < N_PORTS; i++) begin
				if (req[i] && !(grant[i] && !grant_hold)) begin
					hold_valid[i] <= 1'b1;
				end else if (grant[i] && grant_hold) begin
					hold_valid[i] <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < N_PORTS; i++) begin
			if (req[i]) begin
				hold_addr[i]  <= src_haddr[i];
				hold_write[i] <= src_hwrite[i];
				hold_size[i]  <= src_hsize[i];
			end
		end
	end

	// Write data and responses follow the data phase owner
	always_comb begin
		dst_hwdata = '0;
		for (int i = 0; i < N_PORTS; i++) begin
			src_hrdata[i]      = dst_hrdata;
			src_hready_resp[i] = 1'b1;
			src_hresp[i]       = HRESP_OKAY;
			if (hold_valid[i]) begin
				src_hready_resp[i] = 1'b0;
			end else if (dp_owner[i]) begin
				dst_hwdata         = src_hwdata[i];
				src_hready_resp[i] = dst_hready_resp;
				src_hresp[i]       = dst_hresp;
			end
		end
	end

endmodule

/* hw/ahbl_crossbar/ahbl_crossbar.sv */
// Masters-by-slaves AHB-Lite crossbar built from splitters and arbiters
`timescale 1ns/10ps

module ahbl_crossbar (
	input  logic                                                      clk,
	input  logic                                                      rst,

	// Master side
	input  logic [xbar_cfg_pkg::N_MASTERS-1:0][ahbl_pkg::W_ADDR-1:0]  src_haddr,
	input  logic [xbar_cfg_pkg::N_MASTERS-1:0]                        src_hwrite,
	input  ahbl_pkg::ahbl_trans_t [xbar_cfg_pkg::N_MASTERS-1:0]       src_htrans,
	input  ahbl_pkg::ahbl_size_t [xbar_cfg_pkg::N_MASTERS-1:0]        src_hsize,
	input  logic [xbar_cfg_pkg::N_MASTERS-1:0][ahbl_pkg::W_DATA-1:0]  src_hwdata,
	output logic [xbar_cfg_pkg::N_MASTERS-1:0][ahbl_pkg::W_DATA-1:0]  src_hrdata,
	output logic [xbar_cfg_pkg::N_MASTERS-1:0]                        src_hready_resp,
	output ahbl_pkg::ahbl_resp_t [xbar_cfg_pkg::N_MASTERS-1:0]        src_hresp,

	// Slave side
	output logic [xbar_cfg_pkg::N_SLAVES-1:0]                         dst_hready,
	output logic [xbar_cfg_pkg::N_SLAVES-1:0][ahbl_pkg::W_ADDR-1:0]   dst_haddr,
	output logic [xbar_cfg_pkg::N_SLAVES-1:0]                         dst_hwrite,
	output ahbl_pkg::ahbl_trans_t [xbar_cfg_pkg::N_SLAVES-1:0]        dst_htrans,
	output ahbl_pkg::ahbl_size_t [xbar_cfg_pkg::N_SLAVES-1:0]         dst_hsize,
	output logic [xbar_cfg_pkg::N_SLAVES-1:0][ahbl_pkg::W_DATA-1:0]   dst_hwdata,
	input  logic [xbar_cfg_pkg::N_SLAVES-1:0][ahbl_pkg::W_DATA-1:0]   dst_hrdata,
	input  logic [xbar_cfg_pkg::N_SLAVES-1:0]                         dst_hready_resp,
	input  ahbl_pkg::ahbl_resp_t [xbar_cfg_pkg::N_SLAVES-1:0]         dst_hresp
);

	import ahbl_pkg::*;
	import xbar_cfg_pkg::*;

	// ========================================================================
	// Mesh, indexed [master][slave]
	// ========================================================================

	logic [N_MASTERS-1:0][N_SLAVES-1:0]             x_hready;
	logic [N_MASTERS-1:0][N_SLAVES-1:0][W_ADDR-1:0] x_haddr;
	logic [N_MASTERS-1:0][N_SLAVES-1:0]             x_hwrite;
	ahbl_trans_t [N_MASTERS-1:0][N_SLAVES-1:0]      x_htrans;
	ahbl_size_t [N_MASTERS-1:0][N_SLAVES-1:0]       x_hsize;
	logic [N_MASTERS-1:0][N_SLAVES-1:0][W_DATA-1:0] x_hwdata;
	logic [N_MASTERS-1:0][N_SLAVES-1:0][W_DATA-1:0] x_hrdata;
	logic [N_MASTERS-1:0][N_SLAVES-1:0]             x_hready_resp;
	ahbl_resp_t [N_MASTERS-1:0][N_SLAVES-1:0]       x_hresp;

	// Splitter i drives row i; each master's hready is its own hready_resp
	for (genvar i = 0; i < N_MASTERS; i++) begin : g_split
		ahbl_splitter #(.N_PORTS(N_SLAVES)) u_split (
			.clk             (clk),
			.rst             (rst),
			.src_haddr       (src_haddr[i]),
			.src_hwrite      (src_hwrite[i]),
			.src_htrans      (src_htrans[i]),
			.src_hsize       (src_hsize[i]),
			.src_hwdata      (src_hwdata[i]),
			.src_hrdata      (src_hrdata[i]),
			.src_hready_resp (src_hready_resp[i]),
			.src_hresp       (src_hresp[i]),
			.dst_hready      (x_hready[i]),
			.dst_haddr       (x_haddr[i]),
			.dst_hwrite      (x_hwrite[i]),
			.dst_htrans      (x_htrans[i]),
			.dst_hsize       (x_hsize[i]),
			.dst_hwdata      (x_hwdata[i]),
			.dst_hrdata      (x_hrdata[i]),
			.dst_hready_resp (x_hready_resp[i]),
			.dst_hresp       (x_hresp[i])
		);
	end

	// Arbiter j reads column j
	for (genvar j = 0; j < N_SLAVES; j++) begin : g_arb
		logic [N_MASTERS-1:0]             col_hready;
		logic [N_MASTERS-1:0][W_ADDR-1:0] col_haddr;
		logic [N_MASTERS-1:0]             col_hwrite;
		ahbl_trans_t [N_MASTERS-1:0]      col_htrans;
		ahbl_size_t [N_MASTERS-1:0]       col_hsize;
		logic [N_MASTERS-1:0][W_DATA-1:0] col_hwdata;
		logic [N_MASTERS-1:0][W_DATA-1:0] col_hrdata;
		logic [N_MASTERS-1:0]             col_hready_resp;
		ahbl_resp_t [N_MASTERS-1:0]       col_hresp;

		for (genvar i = 0; i < N_MASTERS; i++) begin : g_col
			assign col_hready[i]       = x_hready[i][j];
			assign col_haddr[i]        = x_haddr[i][j];
			assign col_hwrite[i]       = x_hwrite[i][j];
			assign col_htrans[i]       = x_htrans[i][j];
			assign col_hsize[i]        = x_hsize[i][j];
			assign col_hwdata[i]       = x_hwdata[i][j];
			assign x_hrdata[i][j]      = col_hrdata[i];
			assign x_hready_resp[i][j] = col_hready_resp[i];
			assign x_hresp[i][j]       = col_hresp[i];
		end

		ahbl_arbiter #(.N_PORTS(N_MASTERS)) u_arb (
			.clk             (clk),
			.rst             (rst),
			.src_hready      (col_hready),
			.src_haddr       (col_haddr),
			.src_hwrite      (col_hwrite),
			.src_htrans      (col_htrans),
			.src_hsize       (col_hsize),
			.src_hwdata      (col_hwdata),
			.src_hrdata      (col_hrdata),
			.src_hready_resp (col_hready_resp),
			.src_hresp       (col_hresp),
			.dst_hready      (dst_hready[j]),
			.dst_haddr       (dst_haddr[j]),
			.dst_hwrite      (dst_hwrite[j]),
			.dst_htrans      (dst_htrans[j]),
			.dst_hsize       (dst_hsize[j]),
			.dst_hwdata      (dst_hwdata[j]),
			.dst_hrdata      (dst_hrdata[j]),
			.dst_hready_resp (dst_hready_resp[j]),
			.dst_hresp       (dst_hresp[j])
		);
	end

endmodule

/* hw/ahbl_crossbar/ahbl_splitter.sv */
// Per-master AHB-Lite address decoder with data-phase steering and ERROR responder
`timescale 1ns/10ps

module ahbl_splitter #(
	parameter int N_PORTS = xbar_cfg_pkg::N_SLAVES
) (
	input  logic                                         clk,
	input  logic                                         rst,

	// Source side, facing one master
	input  logic [ahbl_pkg::W_ADDR-1:0]                  src_haddr,
	input  logic                                         src_hwrite,
	input  ahbl_pkg::ahbl_trans_t                        src_htrans,
	input  ahbl_pkg::ahbl_size_t                         src_hsize,
	input  logic [ahbl_pkg::W_DATA-1:0]                  src_hwdata,
	output logic [ahbl_pkg::W_DATA-1:0]                  src_hrdata,
	output logic                                         src_hready_resp,
	output ahbl_pkg::ahbl_resp_t                         src_hresp,

	// Destination side, one port per slave
	output logic [N_PORTS-1:0]                           dst_hready,
	output logic [N_PORTS-1:0][ahbl_pkg::W_ADDR-1:0]     dst_haddr,
	output logic [N_PORTS-1:0]                           dst_hwrite,
	output ahbl_pkg::ahbl_trans_t [N_PORTS-1:0]          dst_htrans,
	output ahbl_pkg::ahbl_size_t [N_PORTS-1:0]           dst_hsize,
	output logic [N_PORTS-1:0][ahbl_pkg::W_DATA-1:0]     dst_hwdata,
	input  logic [N_PORTS-1:0][ahbl_pkg::W_DATA-1:0]     dst_hrdata,
	input  logic [N_PORTS-1:0]                           dst_hready_resp,
	input  ahbl_pkg::ahbl_resp_t [N_PORTS-1:0]           dst_hresp
);

	import ahbl_pkg::*;
	import xbar_cfg_pkg::*;

	logic [N_PORTS-1:0] hit;
	logic [N_PORTS-1:0] dp_sel;
	logic               accept;
	logic               err_first;
	logic               err_second;

	// Address decode against the slave map
	always_comb begin
		for (int j = 0; j < N_PORTS; j++) begin
			hit[j] = (src_haddr & SLAVE_MASK[j]) == SLAVE_BASE[j];
		end
	end

	// The master samples its own hready_resp as hready
	assign accept = src_hready_resp && (src_htrans == HTRANS_NONSEQ);

	// ========================================================================
	// Address phase fan-out
	// ========================================================================

	always_comb begin
		for (int j = 0; j < N_PORTS; j++) begin
			dst_hready[j] = src_hready_resp;
			dst_haddr[j]  = src_haddr;
			dst_hwrite[j] = src_hwrite;
			dst_hsize[j]  = src_hsize;
			dst_hwdata[j] = src_hwdata;
			// Only the addressed slave sees the transfer
			dst_htrans[j] = hit[j] ? src_htrans : HTRANS_IDLE;
		end
	end

	// ========================================================================
	// Data phase tracking
	// ========================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			dp_sel     <= '0;
			err_first  <= 1'b0;
			err_second <= 1'b0;
		end else begin
			if (src_hready_resp) begin
				dp_sel <= accept ? hit : '0;
			end
			// Miss starts the two-cycle ERROR response
			err_first  <= accept && !(|hit);
			err_second <= err_first;
		end
	end

	// Response mux back to the master
	always_comb begin
		src_hrdata      = '0;
		src_hready_resp = 1'b1;
		src_hresp       = HRESP_OKAY;
		if (err_first) begin
			src_hready_resp = 1'b0;
			src_hresp       = HRESP_ERROR;
		end else if (err_second) begin
			src_hresp = HRESP_ERROR;
		end else begin
			for (int j = 0; j < N_PORTS; j++) begin
				if (dp_sel[j]) begin
					src_hrdata      = dst_hrdata[j];
					src_hready_resp = dst_hready_resp[j];
					src_hresp       = dst_hresp[j];
				end
			end
		end
	end

endmodule

/* hw/ahbl_sram.sv */
// AHB-Lite SRAM slave with byte lanes and one wait state on reads
`timescale 1ns/10ps

module ahbl_sram (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        hready,
	input  logic [ahbl_pkg::W_ADDR-1:0] haddr,
	input  logic                        hwrite,
	input  ahbl_pkg::ahbl_trans_t       htrans,
	input  ahbl_pkg::ahbl_size_t        hsize,
	input  logic [ahbl_pkg::W_DATA-1:0] hwdata,
	output logic [ahbl_pkg::W_DATA-1:0] hrdata,
	output logic                        hready_resp,
	output ahbl_pkg::ahbl_resp_t        hresp
);

	import ahbl_pkg::*;
	import xbar_cfg_pkg::*;

	logic [W_DATA-1:0]     mem [SRAM_WORDS];
	logic                  accept;
	logic [BYTE_LANES-1:0] lanes;
	logic [SRAM_IDX_W-1:0] dp_idx;
	logic [BYTE_LANES-1:0] dp_lanes;
	logic                  dp_write;
	logic                  rd_wait;

	assign accept = hready && (htrans == HTRANS_NONSEQ);

	// Byte lanes touched by the transfer
	always_comb begin
		case (hsize)
			HSIZE_BYTE: lanes = BYTE_LANES'(1) << haddr[1:0];
			HSIZE_HALF: lanes = BYTE_LANES'(3) << {haddr[1], 1'b0};
			default:    lanes = '1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			dp_write <= 1'b0;
			rd_wait  <= 1'b0;
		end else if (rd_wait) begin
			rd_wait <= 1'b0;
		end else if (hready) begin
			dp_write <= accept && hwrite;
			rd_wait  <= accept && !hwrite;
		end
	end

	// Address capture, write data phase and read fetch
	always_ff @(posedge clk) begin
		if (accept) begin
			dp_idx   <= haddr[2 +: SRAM_IDX_W];
			dp_lanes <= lanes;
		end
		if (dp_write) begin
			for (int b = 0; b < BYTE_LANES; b++) begin
				if (dp_lanes[b]) begin
					mem[dp_idx][8*b +: 8] <= hwdata[8*b +: 8];
				end
			end
		end
		if (rd_wait) begin
			hrdata <= mem[dp_idx];
		end
	end

	assign hready_resp = !rd_wait;
	assign hresp       = HRESP_OKAY;

endmodule

/* hw/ahbl_xbar_sys.sv */
// Top level with the AHB-Lite crossbar and one SRAM slave per slave port
`timescale 1ns/10ps

module ahbl_xbar_sys (
	input  logic                                                      clk,
	input  logic                                                      rst,
	input  logic [xbar_cfg_pkg::N_MASTERS-1:0][ahbl_pkg::W_ADDR-1:0]  m_haddr,
	input  logic [xbar_cfg_pkg::N_MASTERS-1:0]                        m_hwrite,
	input  ahbl_pkg::ahbl_trans_t [xbar_cfg_pkg::N_MASTERS-1:0]       m_htrans,
	input  ahbl_pkg::ahbl_size_t [xbar_cfg_pkg::N_MASTERS-1:0]        m_hsize,
	input  logic [xbar_cfg_pkg::N_MASTERS-1:0][ahbl_pkg::W_DATA-1:0]  m_hwdata,
	output logic [xbar_cfg_pkg::N_MASTERS-1:0][ahbl_pkg::W_DATA-1:0]  m_hrdata,
	output logic [xbar_cfg_pkg::N_MASTERS-1:0]                        m_hready_resp,
	output ahbl_pkg::ahbl_resp_t [xbar_cfg_pkg::N_MASTERS-1:0]        m_hresp
);

	import ahbl_pkg::*;
	import xbar_cfg_pkg::*;

	// Slave-side buses
	logic [N_SLAVES-1:0]             s_hready;
	logic [N_SLAVES-1:0][W_ADDR-1:0] s_haddr;
	logic [N_SLAVES-1:0]             s_hwrite;
	ahbl_trans_t [N_SLAVES-1:0]      s_htrans;
	ahbl_size_t [N_SLAVES-1:0]       s_hsize;
	logic [N_SLAVES-1:0][W_DATA-1:0] s_hwdata;
	logic [N_SLAVES-1:0][W_DATA-1:0] s_hrdata;
	logic [N_SLAVES-1:0]             s_hready_resp;
	ahbl_resp_t [N_SLAVES-1:0]       s_hresp;

	ahbl_crossbar u_xbar (
		.clk             (clk),
		.rst             (rst),
		.src_haddr       (m_haddr),
		.src_hwrite      (m_hwrite),
		.src_htrans      (m_htrans),
		.src_hsize       (m_hsize),
		.src_hwdata      (m_hwdata),
		.src_hrdata      (m_hrdata),
		.src_hready_resp (m_hready_resp),
		.src_hresp       (m_hresp),
		.dst_hready      (s_hready),
		.dst_haddr       (s_haddr),
		.dst_hwrite      (s_hwrite),
		.dst_htrans      (s_htrans),
		.dst_hsize       (s_hsize),
		.dst_hwdata      (s_hwdata),
		.dst_hrdata      (s_hrdata),
		.dst_hready_resp (s_hready_resp),
		.dst_hresp       (s_hresp)
	);

	for (genvar j = 0; j < N_SLAVES; j++) begin : g_sram
		ahbl_sram u_sram (
			.clk         (clk),
			.rst         (rst),
			.hready      (s_hready[j]),
			.haddr       (s_haddr[j]),
			.hwrite      (s_hwrite[j]),
			.htrans      (s_htrans[j]),
			.hsize       (s_hsize[j]),
			.hwdata      (s_hwdata[j]),
			.hrdata      (s_hrdata[j]),
			.hready_resp (s_hready_resp[j]),
			.hresp       (s_hresp[j])
		);
	end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build the crossbar testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
	--top-module tb_ahbl_xbar_sys \
	-f ahbl_xbar.f \
	-o tb_ahbl_xbar_sys

# A $fatal in the testbench gives a failing exit status
./obj_dir/tb_ahbl_xbar_sys

/* verif/tb_ahbl_xbar_sys.sv */
// Table-driven testbench for the two-master AHB-Lite crossbar with SRAM slaves
`timescale 1ns/10ps

module tb_ahbl_xbar_sys;

	import ahbl_pkg::*;
	import xbar_cfg_pkg::*;

	localparam int          CLK_PERIOD   = 20;
	localparam int          RESET_CYCLES = 10;
	localparam int          N_TESTS      = 19;
	localparam int          MAX_CYCLES   = N_TESTS * 8 + 50;
	localparam int unsigned SEED         = 32'h8dafe730;

	// One master operation of a table entry
	typedef struct packed {
		logic              valid;
		logic              write;
		logic [W_ADDR-1:0] addr;
		logic [W_DATA-1:0] wdata;
		ahbl_resp_t        exp_resp;
	} op_t;

	logic                                  clk;
	logic                                  rst;
	logic [N_MASTERS-1:0][W_ADDR-1:0]      m_haddr;
	logic [N_MASTERS-1:0]                  m_hwrite;
	ahbl_trans_t [N_MASTERS-1:0]           m_htrans;
	ahbl_size_t [N_MASTERS-1:0]            m_hsize;
	logic [N_MASTERS-1:0][W_DATA-1:0]      m_hwdata;
	logic [N_MASTERS-1:0][W_DATA-1:0]      m_hrdata;
	logic [N_MASTERS-1:0]                  m_hready_resp;
	ahbl_resp_t [N_MASTERS-1:0]            m_hresp;

	string                                 names [N_TESTS];
	op_t                                   ops [N_TESTS][N_MASTERS];
	int                                    n_entries;
	int                                    cycle_count;
	// Expected memory contents by byte address
	logic [W_DATA-1:0]                     shadow [logic [W_ADDR-1:0]];

	ahbl_xbar_sys UUT (
		.clk           (clk),
		.rst           (rst),
		.m_haddr       (m_haddr),
		.m_hwrite      (m_hwrite),
		.m_htrans      (m_htrans),
		.m_hsize       (m_hsize),
		.m_hwdata      (m_hwdata),
		.m_hrdata      (m_hrdata),
		.m_hready_resp (m_hready_resp),
		.m_hresp       (m_hresp)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Run limit
	initial begin
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout after %0d clock cycles, a transfer never finished", cycle_count);
		$display("Test failed");
		$fatal(1, "Run stopped by the cycle limit");
	end

	// ========================================================================
	// Compare tasks
	// ========================================================================

	task automatic check_data(input string name, input logic [W_DATA-1:0] exp,
			input logic [W_DATA-1:0] act);
		if (act !== exp) begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			$display("Test failed");
			$fatal(1, "Read data mismatch");
		end
	endtask

	task automatic check_resp(input string name, input ahbl_resp_t exp, input ahbl_resp_t act);
		if (act !== exp) begin
			$display("Fail %s: expected %b, actual %b", name, exp, act);
			$display("Test failed");
			$fatal(1, "Response mismatch");
		end
	endtask

	task automatic check_ready(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Fail %s: expected %b, actual %b", name, exp, act);
			$display("Test failed");
			$fatal(1, "Ready mismatch");
		end
	endtask

	// ========================================================================
	// Stimulus table
	// ========================================================================

	function automatic op_t make_op(input logic write, input logic [W_ADDR-1:0] addr,
			input ahbl_resp_t resp);
		op_t op;
		op.valid    = 1'b1;
		op.write    = write;
		op.addr     = addr;
		op.wdata    = write ? $urandom : '0;
		op.exp_resp = resp;
		return op;
	endfunction

	task automatic add_entry(input string name, input op_t op0, input op_t op1);
		names[n_entries]  = name;
		ops[n_entries][0] = op0;
		ops[n_entries][1] = op1;
		n_entries++;
	endtask

	task automatic build_table();
		n_entries = 0;
		// Single master on each slave
		add_entry("m0_wr_s0", make_op(1'b1, 32'h0000_0010, HRESP_OKAY), '0);
		add_entry("m0_rd_s0", make_op(1'b0, 32'h0000_0010, HRESP_OKAY), '0);
		add_entry("m0_wr_s1", make_op(1'b1, 32'h1000_0020, HRESP_OKAY), '0);
		add_entry("m0_rd_s1", make_op(1'b0, 32'h1000_0020, HRESP_OKAY), '0);
		add_entry("m1_wr_s0", '0, make_op(1'b1, 32'h0000_0030, HRESP_OKAY));
		add_entry("m1_rd_s0", '0, make_op(1'b0, 32'h0000_0030, HRESP_OKAY));
		add_entry("m1_wr_s1", '0, make_op(1'b1, 32'h1000_0040, HRESP_OKAY));
		add_entry("m1_rd_s1", '0, make_op(1'b0, 32'h1000_0040, HRESP_OKAY));
		// Contention on one slave
		add_entry("both_wr_s0", make_op(1'b1, 32'h0000_0100, HRESP_OKAY),
			make_op(1'b1, 32'h0000_0104, HRESP_OKAY));
		add_entry("both_rd_s0", make_op(1'b0, 32'h0000_0104, HRESP_OKAY),
			make_op(1'b0, 32'h0000_0100, HRESP_OKAY));
		add_entry("rd_wr_s1", make_op(1'b0, 32'h1000_0020, HRESP_OKAY),
			make_op(1'b1, 32'h1000_0024, HRESP_OKAY));
		add_entry("rd_back_s1", '0, make_op(1'b0, 32'h1000_0024, HRESP_OKAY));
		// Parallel access to the same word offset in both slaves
		add_entry("split_wr", make_op(1'b1, 32'h1000_0200, HRESP_OKAY),
			make_op(1'b1, 32'h0000_0200, HRESP_OKAY));
		add_entry("split_rd", make_op(1'b0, 32'h0000_0200, HRESP_OKAY),
			make_op(1'b0, 32'h1000_0200, HRESP_OKAY));
		add_entry("iso_wr_s1", '0, make_op(1'b1, 32'h1000_0010, HRESP_OKAY));
		// Unmapped region
		add_entry("err_rd", make_op(1'b0, 32'h2000_0000, HRESP_ERROR), '0);
		add_entry("err_wr", make_op(1'b0, 32'h0000_0104, HRESP_OKAY),
			make_op(1'b1, 32'h3000_0010, HRESP_ERROR));
		add_entry("post_err_rd", make_op(1'b0, 32'h0000_0010, HRESP_OKAY),
			make_op(1'b0, 32'h1000_0010, HRESP_OKAY));
		add_entry("post_err_rd2", make_op(1'b0, 32'h1000_0020, HRESP_OKAY),
			make_op(1'b0, 32'h0000_0030, HRESP_OKAY));
	endtask

	// ========================================================================
	// Bus transfers
	// ========================================================================

	// Both address phases go out on the same falling edge
	task automatic run_entry(input int k);
		op_t                  op [N_MASTERS];
		logic [W_DATA-1:0]    exp_data [N_MASTERS];
		logic [W_DATA-1:0]    got_data [N_MASTERS];
		ahbl_resp_t           got_resp [N_MASTERS];
		logic [N_MASTERS-1:0] pending;
		string                name;
		for (int i = 0; i < N_MASTERS; i++) begin
			op[i]       = ops[k][i];
			pending[i]  = op[i].valid;
			exp_data[i] = '0;
			if (op[i].valid && !op[i].write && op[i].exp_resp == HRESP_OKAY) begin
				exp_data[i] = shadow[op[i].addr];
			end
			if (op[i].valid) begin
				m_haddr[i]  = op[i].addr;
				m_hwrite[i] = op[i].write;
				m_hsize[i]  = HSIZE_WORD;
				m_htrans[i] = HTRANS_NONSEQ;
			end
		end
		@(negedge clk);
		for (int i = 0; i < N_MASTERS; i++) begin
			m_htrans[i] = HTRANS_IDLE;
			if (op[i].valid && op[i].write) begin
				m_hwdata[i] = op[i].wdata;
			end
		end
		// A master's data phase ends on the next rising edge once hready_resp is high
		while (|pending) begin
			#1;
			for (int i = 0; i < N_MASTERS; i++) begin
				if (pending[i] && m_hready_resp[i]) begin
					got_data[i] = m_hrdata[i];
					got_resp[i] = m_hresp[i];
					pending[i]  = 1'b0;
				end
			end
			@(negedge clk);
		end
		for (int i = 0; i < N_MASTERS; i++) begin
			name = $sformatf("%s m%0d", names[k], i);
			if (op[i].valid) begin
				check_resp(name, op[i].exp_resp, got_resp[i]);
				if (!op[i].write && op[i].exp_resp == HRESP_OKAY) begin
					check_data(name, exp_data[i], got_data[i]);
				end
				if (op[i].write && op[i].exp_resp == HRESP_OKAY) begin
					shadow[op[i].addr] = op[i].wdata;
				end
			end
		end
	endtask

	initial begin
		void'($urandom(SEED));
		rst        = 1'b1;
		m_haddr    = '0;
		m_hwrite   = '0;
		m_hwdata   = '0;
		for (int i = 0; i < N_MASTERS; i++) begin
			m_htrans[i] = HTRANS_IDLE;
			m_hsize[i]  = HSIZE_WORD;
		end
		build_table();
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		// Idle bus right after reset
		for (int i = 0; i < N_MASTERS; i++) begin
			check_ready($sformatf("reset m%0d", i), 1'b1, m_hready_resp[i]);
			check_resp($sformatf("reset m%0d", i), HRESP_OKAY, m_hresp[i]);
		end
		for (int k = 0; k < n_entries; k++) begin
			run_entry(k);
		end
		$display("Test passed");
		$finish;
	end

endmodule
